// ==== apb_subsys_top.f ====
hw/apb_subsys_pkg.sv
hw/ahb_apb_bridge.sv
hw/apb_gpio.sv
hw/apb_uart_tx.sv
hw/apb_subsys_top.sv
verification/apb_subsys_asserts.sv
verification/apb_subsys_tb.sv

// ==== Makefile ====
TOP := apb_subsys_tb

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) \
	  -f apb_subsys_top.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== verification/apb_subsys_tb.sv ====
// Directed testbench for the APB subsystem
`default_nettype none

module apb_subsys_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import apb_subsys_pkg::*;

  localparam int HREADY_LIMIT = 16;  // Cycles allowed per transfer
  localparam int UART_BIT     = 3;   // Divisor used in the UART test

  logic       tb_hclk14;
  logic       hresetn14;
  logic       i_hsel;
  logic       i_hready_in;
  logic       i_hwrite;
  logic [1:0] i_htrans;
  addr_t      i_haddr;
  data_t      i_hwdata;
  data_t      o_hrdata;
  logic       o_hready;
  logic       o_hresp;
  gpio_t      i_gpio_in;
  gpio_t      o_gpio_out;
  gpio_t      o_gpio_oe;
  logic       o_uart_txd;

  logic [31:0] lfsr_q = 32'hdd81;
  int          err_count = 0;
  int          test_count = 0;
  int          test_fail = 0;
  int          errs_at_start;
  string       cur_test;
  logic        first_resp;   // hresp in first data phase cycle
  logic        last_resp;    // hresp when hready rose
  int          last_cycles;  // Cycles from acceptance to hready
  gpio_t       exp_dout;     // Expected GPIO registers
  gpio_t       exp_oe;

  apb_subsys_top dut (.*);

  always #2 tb_hclk14 = ~tb_hclk14;  // 4 ns period

  // ========================================
  // Helpers
  // ========================================
  // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic data_t take_bits(input int n);
    data_t v;
    logic  fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic addr_t reg_addr(input logic [3:0] sel, input logic [7:0] off);
    return {16'h0000, sel, 4'h0, off};  // Select in bits 15:12
  endfunction

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_gpio(input string what, input gpio_t exp, input gpio_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected 0x%04h actual 0x%04h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %b actual %b", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("ERROR %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    errs_at_start = err_count;
    test_count++;
  endtask

  task automatic report_test();
    if (err_count == errs_at_start) begin
      $display("Test %s: ok", cur_test);
    end else begin
      test_fail++;
      $display("Test %s: %0d error(s)", cur_test, err_count - errs_at_start);
    end
  endtask

  // ========================================
  // AHB driver
  // ========================================
  // Called on a falling edge with hready high
  task automatic ahb_transfer(input logic write, input addr_t addr, input data_t wdata,
                              output data_t rdata);
    int cycles;
    i_hsel   = 1'b1;
    i_htrans = HTRANS_NONSEQ;
    i_hwrite = write;
    i_haddr  = addr;
    @(negedge tb_hclk14);  // Accepted on the rising edge before
    i_hsel     = 1'b0;
    i_htrans   = HTRANS_IDLE;
    i_hwdata   = wdata;    // Data phase
    first_resp = o_hresp;
    cycles     = 1;
    while (!o_hready && cycles < HREADY_LIMIT) begin
      @(negedge tb_hclk14);
      cycles++;
    end
    if (!o_hready) begin
      $display("Test %s: o_hready stayed low for %0d cycles at 0x%08h",
               cur_test, cycles, addr);
      err_count++;
    end
    rdata       = o_hrdata;
    last_resp   = o_hresp;
    last_cycles = cycles;
  endtask

  task automatic ahb_write(input addr_t addr, input data_t wdata);
    data_t unused;
    ahb_transfer(1'b1, addr, wdata, unused);
  endtask

  task automatic ahb_read(input addr_t addr, output data_t rdata);
    ahb_transfer(1'b0, addr, '0, rdata);
  endtask

  // Mid-bit samples of one frame
  task automatic sample_frame(input byte_t tx_byte, input int bit_cycles);
    int waited;
    waited = 0;
    while (o_uart_txd && waited < 64) begin
      @(negedge tb_hclk14);
      waited++;
    end
    if (o_uart_txd) begin
      $display("Test %s: no start bit on o_uart_txd", cur_test);
      err_count++;
    end else begin
      repeat (bit_cycles / 2) @(negedge tb_hclk14);
      check_bit("start bit", 1'b0, o_uart_txd);
      for (int i = 0; i < 8; i++) begin
        repeat (bit_cycles) @(negedge tb_hclk14);
        check_bit("data bit", tx_byte[i], o_uart_txd);  // LSB first
      end
      repeat (bit_cycles) @(negedge tb_hclk14);
      check_bit("stop bit", 1'b1, o_uart_txd);
    end
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic test_reset();
    data_t rd;
    begin_test("reset");
    check_bit("uart txd", 1'b1, o_uart_txd);
    check_gpio("gpio oe", 16'h0000, o_gpio_oe);
    check_gpio("gpio out", 16'h0000, o_gpio_out);
    check_bit("hready", 1'b1, o_hready);
    ahb_read(reg_addr(SEL_UART, UART_DIV), rd);
    check_data("uart divisor", 32'd4, rd);
    ahb_read(reg_addr(SEL_UART, UART_STATUS), rd);
    check_data("uart status", 32'd0, rd);
    report_test();
  endtask

  task automatic test_gpio_out();
    data_t wd_out;
    data_t wd_oe;
    data_t rd;
    begin_test("gpio_out");
    repeat (3) begin
      wd_out   = take_bits(32);  // Upper half is not stored
      wd_oe    = take_bits(32);
      exp_dout = wd_out[15:0];
      exp_oe   = wd_oe[15:0];
      ahb_write(reg_addr(SEL_GPIO, GPIO_DOUT), wd_out);
      ahb_write(reg_addr(SEL_GPIO, GPIO_OE), wd_oe);
      ahb_read(reg_addr(SEL_GPIO, GPIO_DOUT), rd);
      check_data("dout readback", {16'h0000, exp_dout}, rd);
      ahb_read(reg_addr(SEL_GPIO, GPIO_OE), rd);
      check_data("oe readback", {16'h0000, exp_oe}, rd);
      check_gpio("o_gpio_out", exp_dout, o_gpio_out);
      check_gpio("o_gpio_oe", exp_oe, o_gpio_oe);
    end
    report_test();
  endtask

  task automatic test_gpio_in();
    gpio_t pins;
    data_t rd;
    begin_test("gpio_in");
    repeat (4) begin
      pins      = gpio_t'(take_bits(16));
      i_gpio_in = pins;
      repeat (3) @(negedge tb_hclk14);  // Through the synchronizer
      ahb_read(reg_addr(SEL_GPIO, GPIO_DIN), rd);
      check_data("din", {16'h0000, pins}, rd);
      check_count("hready cycles", 3, last_cycles);
      check_bit("hresp", HRESP_OKAY, last_resp);
    end
    report_test();
  endtask

  task automatic test_uart();
    byte_t tx_byte;
    data_t rd;
    int    elapsed;
    logic  idle_seen;
    logic  quiet;
    begin_test("uart");
    ahb_write(reg_addr(SEL_UART, UART_DIV), UART_BIT);
    tx_byte = byte_t'(take_bits(8));
    fork
      sample_frame(tx_byte, UART_BIT);
      begin
        ahb_write(reg_addr(SEL_UART, UART_TXDATA), {24'h0, tx_byte});
        ahb_read(reg_addr(SEL_UART, UART_STATUS), rd);
        check_data("status busy", 32'd1, rd);
        ahb_write(reg_addr(SEL_UART, UART_TXDATA), {24'h0, ~tx_byte});  // Dropped
      end
    join
    // Busy clears within 10 bit times
    elapsed   = 0;
    idle_seen = 1'b0;
    while (!idle_seen && elapsed < 10 * UART_BIT) begin
      ahb_read(reg_addr(SEL_UART, UART_STATUS), rd);
      elapsed   = elapsed + last_cycles;
      idle_seen = (rd == 32'd0);
    end
    if (!idle_seen) begin
      $display("Test %s: UART status still busy after %0d cycles", cur_test, elapsed);
      err_count++;
    end
    quiet = 1'b1;
    repeat (10 * UART_BIT) begin
      @(negedge tb_hclk14);
      if (!o_uart_txd) quiet = 1'b0;
    end
    check_bit("line idle after frame", 1'b1, quiet);
    report_test();
  endtask

  task automatic test_unmapped();
    data_t rd;
    begin_test("unmapped");
    ahb_read(reg_addr(4'h5, 8'h00), rd);
    check_bit("read first resp", HRESP_ERROR, first_resp);
    check_bit("read last resp", HRESP_ERROR, last_resp);
    check_count("read error cycles", 2, last_cycles);
    ahb_write(reg_addr(4'h5, 8'h04), take_bits(32));
    check_bit("write first resp", HRESP_ERROR, first_resp);
    check_bit("write last resp", HRESP_ERROR, last_resp);
    check_count("write error cycles", 2, last_cycles);
    // Registers untouched
    ahb_read(reg_addr(SEL_GPIO, GPIO_DOUT), rd);
    check_data("dout after error", {16'h0000, exp_dout}, rd);
    check_bit("resp after error", HRESP_OKAY, last_resp);
    ahb_read(reg_addr(SEL_GPIO, GPIO_OE), rd);
    check_data("oe after error", {16'h0000, exp_oe}, rd);
    check_gpio("o_gpio_oe after error", exp_oe, o_gpio_oe);
    report_test();
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    tb_hclk14   = 1'b0;
    hresetn14   = 1'b0;
    i_hsel      = 1'b0;
    i_hready_in = 1'b1;  // Single slave always ready
    i_hwrite    = 1'b0;
    i_htrans    = HTRANS_IDLE;
    i_haddr     = '0;
    i_hwdata    = '0;
    i_gpio_in   = '0;
    exp_dout    = '0;
    exp_oe      = '0;
    repeat (3) @(negedge tb_hclk14);
    hresetn14 = 1'b1;
    test_reset();
    test_gpio_out();
    test_gpio_in();
    test_uart();
    test_unmapped();
    $display("%0d tests run, %0d failed, %0d errors", test_count, test_fail, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/apb_subsys_asserts.sv ====
// APB and AHB protocol assertions
`default_nettype none

module apb_subsys_asserts (
  input wire                           tb_hclk14,
  input wire                           hresetn14,
  input logic                          i_psel_gpio,
  input logic                          i_psel_uart,
  input logic                          i_penable,
  input logic                          i_hready,
  input logic                          i_hresp,
  input apb_subsys_pkg::bridge_state_e i_state
);
  timeunit 1ns;
  timeprecision 100ps;

  import apb_subsys_pkg::*;

  // ========================================
  // APB side
  // ========================================
  a_one_select: assert property (@(posedge tb_hclk14) disable iff (!hresetn14)
    !(i_psel_gpio && i_psel_uart))
    else $error("Both APB selects high");

  a_enable_sel: assert property (@(posedge tb_hclk14) disable iff (!hresetn14)
    i_penable |-> (i_psel_gpio || i_psel_uart))
    else $error("penable high without a select");

  // Setup always moves to access on the same peripheral
  a_setup_access: assert property (@(posedge tb_hclk14) disable iff (!hresetn14)
    ((i_psel_gpio || i_psel_uart) && !i_penable)
      |=> (i_penable && $stable({i_psel_gpio, i_psel_uart})))
    else $error("APB setup cycle not followed by access");

  // AHB error response, low then high hready
  a_error_state: assert property (@(posedge tb_hclk14) disable iff (!hresetn14)
    ((i_hresp == HRESP_ERROR) && !i_hready)
      |=> (i_state == BR_ERROR && i_hresp == HRESP_ERROR && i_hready))
    else $error("ERROR response not two cycles in the bridge error state");

endmodule

bind apb_subsys_top apb_subsys_asserts u_asserts (
  .tb_hclk14   (tb_hclk14),
  .hresetn14   (hresetn14),
  .i_psel_gpio (psel_gpio),
  .i_psel_uart (psel_uart),
  .i_penable   (penable),
  .i_hready    (o_hready),
  .i_hresp     (o_hresp),
  .i_state     (u_bridge.state_q)
);

`default_nettype wire

// ==== hw/apb_subsys_top.sv ====
// APB subsystem top level
`default_nettype none

module apb_subsys_top (
  input  wire                   tb_hclk14,
  input  wire                   hresetn14,
  // AHB-lite
  input  logic                  i_hsel,
  input  logic                  i_hready_in,
  input  logic                  i_hwrite,
  input  logic [1:0]            i_htrans,
  input  apb_subsys_pkg::addr_t i_haddr,
  input  apb_subsys_pkg::data_t i_hwdata,
  output apb_subsys_pkg::data_t o_hrdata,
  output logic                  o_hready,
  output logic                  o_hresp,
  // Pins
  input  apb_subsys_pkg::gpio_t i_gpio_in,
  output apb_subsys_pkg::gpio_t o_gpio_out,
  output apb_subsys_pkg::gpio_t o_gpio_oe,
  output logic                  o_uart_txd
);

  import apb_subsys_pkg::*;

  // ========================================
  // Shared APB bus
  // ========================================
  addr_t paddr;
  data_t pwdata;
  logic  pwrite;
  logic  penable;
  logic  psel_gpio;
  logic  psel_uart;
  data_t prdata_gpio;  // Per peripheral read data
  data_t prdata_uart;

  ahb_apb_bridge u_bridge (
    .tb_hclk14     (tb_hclk14),
    .hresetn14     (hresetn14),
    .i_hsel        (i_hsel),
    .i_hready_in   (i_hready_in),
    .i_hwrite      (i_hwrite),
    .i_htrans      (i_htrans),
    .i_haddr       (i_haddr),
    .i_hwdata      (i_hwdata),
    .o_hrdata      (o_hrdata),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp),
    .o_paddr       (paddr),
    .o_pwrite      (pwrite),
    .o_penable     (penable),
    .o_psel_gpio   (psel_gpio),
    .o_psel_uart   (psel_uart),
    .o_pwdata      (pwdata),
    .i_prdata_gpio (prdata_gpio),
    .i_prdata_uart (prdata_uart)
  );

  apb_gpio u_gpio (
    .tb_hclk14  (tb_hclk14),
    .hresetn14  (hresetn14),
    .i_psel     (psel_gpio),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata_gpio),
    .i_gpio_in  (i_gpio_in),
    .o_gpio_out (o_gpio_out),
    .o_gpio_oe  (o_gpio_oe)
  );

  apb_uart_tx u_uart (
    .tb_hclk14  (tb_hclk14),
    .hresetn14  (hresetn14),
    .i_psel     (psel_uart),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata_uart),
    .o_uart_txd (o_uart_txd)
  );

endmodule

`default_nettype wire

// ==== hw/apb_uart_tx.sv ====
// APB UART transmitter
`default_nettype none

module apb_uart_tx (
  input  wire                   tb_hclk14,
  input  wire                   hresetn14,
  // APB slave
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  apb_subsys_pkg::addr_t i_paddr,
  input  apb_subsys_pkg::data_t i_pwdata,
  output apb_subsys_pkg::data_t o_prdata,
  // Serial line
  output logic                  o_uart_txd
);

  import apb_subsys_pkg::*;

  uart_state_e state_q;

  div_t       div_q;    // Cycles per bit
  div_t       cyc_q;    // Cycle within bit
  logic [2:0] bit_q;    // Data bit index
  byte_t      shift_q;  // LSB goes out first

  div_t       div_eff;
  logic       bit_end;
  logic       wr_en;
  logic       tx_wr;
  logic       div_wr;
  logic       busy;

  assign wr_en  = i_psel && i_penable && i_pwrite;
  assign tx_wr  = wr_en && (i_paddr[7:0] == UART_TXDATA);
  assign div_wr = wr_en && (i_paddr[7:0] == UART_DIV);

  assign div_eff = (div_q == '0) ? div_t'(1) : div_q;  // Zero acts as one
  assign bit_end = (cyc_q == div_eff - div_t'(1));
  assign busy    = (state_q != UART_IDLE);

  // ========================================
  // Frame FSM
  // ========================================
  always_ff @(posedge tb_hclk14) begin
    if (!hresetn14) begin
      state_q <= UART_IDLE;
      div_q   <= UART_DIV_RESET;
      cyc_q   <= '0;
      bit_q   <= '0;
    end else begin
      if (div_wr) div_q <= i_pwdata[15:0];
      cyc_q <= bit_end ? '0 : cyc_q + div_t'(1);  // Bit timer
      unique case (state_q)
        UART_IDLE: begin
          cyc_q <= '0;
          if (tx_wr) state_q <= UART_START;  // Writes while busy dropped
        end
        UART_START: begin
          if (bit_end) begin
            bit_q   <= '0;
            state_q <= UART_DATA;
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            if (bit_q == 3'd7) state_q <= UART_STOP;
            bit_q <= bit_q + 3'd1;
          end
        end
        UART_STOP: begin
          if (bit_end) state_q <= UART_IDLE;
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // Shift register
  always_ff @(posedge tb_hclk14) begin
    if (state_q == UART_IDLE && tx_wr) begin
      shift_q <= i_pwdata[7:0];
    end else if (state_q == UART_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  // Line idles high
  always_comb begin
    case (state_q)
      UART_START: o_uart_txd = 1'b0;
      UART_DATA:  o_uart_txd = shift_q[0];
      default:    o_uart_txd = 1'b1;  // Idle and stop bit
    endcase
  end

  // Read mux, TXDATA is write only
  always_comb begin
    case (i_paddr[7:0])
      UART_STATUS: o_prdata = {31'b0, busy};
      UART_DIV:    o_prdata = {16'b0, div_q};
      default:     o_prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/apb_gpio.sv ====
// APB GPIO port
`default_nettype none

module apb_gpio (
  input  wire                   tb_hclk14,
  input  wire                   hresetn14,
  // APB slave
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  apb_subsys_pkg::addr_t i_paddr,
  input  apb_subsys_pkg::data_t i_pwdata,
  output apb_subsys_pkg::data_t o_prdata,
  // Pins
  input  apb_subsys_pkg::gpio_t i_gpio_in,
  output apb_subsys_pkg::gpio_t o_gpio_out,
  output apb_subsys_pkg::gpio_t o_gpio_oe
);

  import apb_subsys_pkg::*;

  gpio_t dout_q;   // Output value
  gpio_t oe_q;     // Output enable
  gpio_t sync1_q;  // Input synchronizer
  gpio_t sync2_q;

  logic  wr_en;
  logic [7:0] offset;

  assign offset = i_paddr[7:0];
  assign wr_en  = i_psel && i_penable && i_pwrite;  // Access cycle only

  // ========================================
  // Registers
  // ========================================
  always_ff @(posedge tb_hclk14) begin
    if (!hresetn14) begin
      dout_q  <= '0;
      oe_q    <= '0;  // All pins inputs
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= i_gpio_in;
      sync2_q <= sync1_q;
      if (wr_en && offset == GPIO_DOUT) dout_q <= i_pwdata[15:0];
      if (wr_en && offset == GPIO_OE)   oe_q   <= i_pwdata[15:0];
      // DIN is read only
    end
  end

  // Read mux, unknown offsets give 0
  always_comb begin
    case (offset)
      GPIO_DOUT: o_prdata = {16'b0, dout_q};
      GPIO_OE:   o_prdata = {16'b0, oe_q};
      GPIO_DIN:  o_prdata = {16'b0, sync2_q};
      default:   o_prdata = '0;
    endcase
  end

  assign o_gpio_out = dout_q;
  assign o_gpio_oe  = oe_q;

endmodule

`default_nettype wire

// ==== hw/ahb_apb_bridge.sv ====
// AHB-lite to APB bridge
`default_nettype none

module ahb_apb_bridge (
  input  wire                   tb_hclk14,
  input  wire                   hresetn14,
  // AHB-lite slave side
  input  logic                  i_hsel,
  input  logic                  i_hready_in,
  input  logic                  i_hwrite,
  input  logic [1:0]            i_htrans,
  input  apb_subsys_pkg::addr_t i_haddr,
  input  apb_subsys_pkg::data_t i_hwdata,
  output apb_subsys_pkg::data_t o_hrdata,
  output logic                  o_hready,
  output logic                  o_hresp,
  // APB master side
  output apb_subsys_pkg::addr_t o_paddr,
  output logic                  o_pwrite,
  output logic                  o_penable,
  output logic                  o_psel_gpio,
  output logic                  o_psel_uart,
  output apb_subsys_pkg::data_t o_pwdata,
  input  apb_subsys_pkg::data_t i_prdata_gpio,
  input  apb_subsys_pkg::data_t i_prdata_uart
);

  import apb_subsys_pkg::*;

  bridge_state_e state_q, state_d;

  logic  err_last_q;   // Second cycle of error response
  logic  write_q;
  logic  sel_gpio_q;
  logic  sel_uart_q;
  addr_t addr_q;
  data_t pwdata_q;
  data_t hrdata_q;

  logic  xfer_req;
  logic  accept;
  logic  hit_gpio;
  logic  hit_uart;

  // ========================================
  // Address phase
  // ========================================
  assign xfer_req = i_hsel && i_hready_in &&
                    (i_htrans == HTRANS_NONSEQ || i_htrans == HTRANS_SEQ);
  assign accept   = xfer_req && o_hready;  // Only when bridge is free

  assign hit_gpio = (i_haddr[15:12] == SEL_GPIO);
  assign hit_uart = (i_haddr[15:12] == SEL_UART);

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BR_IDLE: begin
        if (accept) state_d = (hit_gpio || hit_uart) ? BR_SETUP : BR_ERROR;
      end
      BR_SETUP:  state_d = BR_ACCESS;  // Always one setup cycle
      BR_ACCESS: state_d = BR_IDLE;    // No wait states
      BR_ERROR: begin
        if (err_last_q) begin
          // Back to back transfer allowed in last error cycle
          if (accept) state_d = (hit_gpio || hit_uart) ? BR_SETUP : BR_ERROR;
          else        state_d = BR_IDLE;
        end
      end
      default: state_d = BR_IDLE;
    endcase
  end

  // ========================================
  // Control registers
  // ========================================
  always_ff @(posedge tb_hclk14) begin
    if (!hresetn14) begin
      state_q    <= BR_IDLE;
      err_last_q <= 1'b0;
      write_q    <= 1'b0;
      sel_gpio_q <= 1'b0;
      sel_uart_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      err_last_q <= (state_q == BR_ERROR) && !err_last_q;  // Two-cycle response
      if (accept) begin
        write_q    <= i_hwrite;
        sel_gpio_q <= hit_gpio;
        sel_uart_q <= hit_uart;
      end
    end
  end

  // Payload, no reset needed
  always_ff @(posedge tb_hclk14) begin
    if (accept) addr_q <= i_haddr;
    if (state_q == BR_SETUP) pwdata_q <= i_hwdata;   // AHB data phase
    if (state_q == BR_ACCESS) begin
      hrdata_q <= sel_gpio_q ? i_prdata_gpio : i_prdata_uart;  // Read mux
    end
  end

  // ========================================
  // Outputs
  // ========================================
  assign o_paddr   = addr_q;
  assign o_pwrite  = write_q;
  assign o_pwdata  = pwdata_q;
  assign o_penable = (state_q == BR_ACCESS);

  // Select held through setup and access
  assign o_psel_gpio = sel_gpio_q && (state_q == BR_SETUP || state_q == BR_ACCESS);
  assign o_psel_uart = sel_uart_q && (state_q == BR_SETUP || state_q == BR_ACCESS);

  assign o_hready = (state_q == BR_IDLE) || (state_q == BR_ERROR && err_last_q);
  assign o_hresp  = (state_q == BR_ERROR) ? HRESP_ERROR : HRESP_OKAY;
  assign o_hrdata = hrdata_q;

endmodule

`default_nettype wire

// ==== hw/apb_subsys_pkg.sv ====
// APB subsystem shared definitions
`default_nettype none

package apb_subsys_pkg;

  // ========================================
  // Widths
  // ========================================
  typedef logic [31:0] addr_t;  // AHB and APB address
  typedef logic [31:0] data_t;  // Bus data word
  typedef logic [15:0] gpio_t;  // GPIO pins
  typedef logic [7:0]  byte_t;  // UART character
  typedef logic [15:0] div_t;   // UART cycles per bit

  // AHB transfer types
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Only low bit of hresp modelled
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // ========================================
  // Address map, haddr[15:12]
  // ========================================
  localparam logic [3:0] SEL_GPIO = 4'h1;
  localparam logic [3:0] SEL_UART = 4'h2;

  // Register offsets, paddr[7:0]
  localparam logic [7:0] GPIO_DOUT   = 8'h00;
  localparam logic [7:0] GPIO_OE     = 8'h04;
  localparam logic [7:0] GPIO_DIN    = 8'h08;
  localparam logic [7:0] UART_TXDATA = 8'h00;
  localparam logic [7:0] UART_STATUS = 8'h04;
  localparam logic [7:0] UART_DIV    = 8'h08;

  localparam div_t UART_DIV_RESET = 16'd4;  // Divisor out of reset

  // FSM states
  typedef enum logic [1:0] {BR_IDLE, BR_SETUP, BR_ACCESS, BR_ERROR} bridge_state_e;
  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage

`default_nettype wire
